// File: common/radar_pkg.sv
// radar package with register map, reset values, widths and the shared stream types
package radar_pkg;

  // datapath and bus widths
  localparam int SAMPLE_W = 16;
  localparam int REG_W    = 32;
  localparam int ADDR_W   = 8;

  // delay-line stages after the tx output register
  localparam int TX_DELAY = 3;

  // register reset values
  localparam logic [REG_W-1:0] PRF_COUNT_INIT         = 32'h0000_0fff;
  localparam logic [REG_W-1:0] ADC_SAMPLES_INIT       = 32'h0000_01fe;
  localparam logic [REG_W-1:0] CHIRP_COUNT_MAX_INIT   = 32'h0000_0dff;
  localparam logic [REG_W-1:0] CHIRP_TUNING_INIT      = 32'h0000_0001;
  localparam logic [REG_W-1:0] CHIRP_FREQ_OFFSET_INIT = 32'h0000_0b00;

  // 90 degrees of phase, puts q ahead of i
  localparam logic [SAMPLE_W-1:0] QUARTER_TURN = 16'h4000;

  // settings and readback address map
  typedef enum logic [ADDR_W-1:0] {
    REG_RUN               = 8'h10,
    REG_PRF_COUNT         = 8'h11,
    REG_ADC_SAMPLES       = 8'h12,
    REG_CHIRP_COUNT_MAX   = 8'h13,
    REG_CHIRP_TUNING      = 8'h14,
    REG_CHIRP_FREQ_OFFSET = 8'h15,
    REG_TX_IDLE           = 8'h16,
    REG_LOOPBACK          = 8'h17,
    REG_TEST              = 8'h18,
    RB_PULSE_COUNT        = 8'h20,
    RB_TXRX               = 8'h21
  } radar_reg_e;

  // single-cycle settings write
  typedef struct packed {
    logic              stb;
    logic [ADDR_W-1:0] addr;
    logic [REG_W-1:0]  data;
  } set_bus_t;

  // i in the upper half, q in the lower half
  typedef struct packed {
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } sample_iq_t;

  typedef struct packed {
    logic [REG_W-1:0] count_max;
    logic [REG_W-1:0] tuning;
    logic [REG_W-1:0] freq_offset;
  } chirp_cfg_t;

  typedef struct packed {
    logic             run;
    logic [REG_W-1:0] prf_count;
    logic [REG_W-1:0] adc_samples;
  } pulse_cfg_t;

  typedef struct packed {
    logic       valid;
    logic       last;
    sample_iq_t sample;
  } chirp_beat_t;

  // paired tx/rx beat on the receive stream
  typedef struct packed {
    logic       first;
    logic       last;
    sample_iq_t dac;
    sample_iq_t adc;
  } iq_beat_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COUNT,
    ST_FIRE
  } pulse_state_e;

endpackage

// File: verilog/radar_settings.sv
// radar settings register bank with combinational readback
module radar_settings (
  input  logic                        clk,
  input  logic                        i_reset,
  input  radar_pkg::set_bus_t         i_set,
  input  radar_pkg::radar_reg_e       i_rb_addr,
  input  logic [radar_pkg::REG_W-1:0] i_pulse_count,
  input  radar_pkg::sample_iq_t       i_tx,
  input  radar_pkg::sample_iq_t       i_rx,
  output logic [radar_pkg::REG_W-1:0] o_rb_data,
  output radar_pkg::pulse_cfg_t       o_pulse_cfg,
  output radar_pkg::chirp_cfg_t       o_chirp_cfg,
  output radar_pkg::sample_iq_t       o_tx_idle,
  output logic                        o_loopback
);

  logic                        run_q;
  logic [radar_pkg::REG_W-1:0] prf_count_q;
  logic [radar_pkg::REG_W-1:0] adc_samples_q;
  logic [radar_pkg::REG_W-1:0] count_max_q;
  logic [radar_pkg::REG_W-1:0] tuning_q;
  logic [radar_pkg::REG_W-1:0] freq_offset_q;
  logic [radar_pkg::REG_W-1:0] test_q;
  radar_pkg::sample_iq_t       tx_idle_q;
  logic                        loopback_q;

  // address decode, new value visible the cycle after the strobe
  always_ff @(posedge clk) begin
    if (i_reset) begin
      run_q         <= 1'b0;
      prf_count_q   <= radar_pkg::PRF_COUNT_INIT;
      adc_samples_q <= radar_pkg::ADC_SAMPLES_INIT;
      count_max_q   <= radar_pkg::CHIRP_COUNT_MAX_INIT;
      tuning_q      <= radar_pkg::CHIRP_TUNING_INIT;
      freq_offset_q <= radar_pkg::CHIRP_FREQ_OFFSET_INIT;
      test_q        <= '0;
      tx_idle_q     <= '0;
      loopback_q    <= 1'b0;
    end else if (i_set.stb) begin
      case (i_set.addr)
        radar_pkg::REG_RUN:               run_q         <= i_set.data[0];
        radar_pkg::REG_PRF_COUNT:         prf_count_q   <= i_set.data;
        radar_pkg::REG_ADC_SAMPLES:       adc_samples_q <= i_set.data;
        radar_pkg::REG_CHIRP_COUNT_MAX:   count_max_q   <= i_set.data;
        radar_pkg::REG_CHIRP_TUNING:      tuning_q      <= i_set.data;
        radar_pkg::REG_CHIRP_FREQ_OFFSET: freq_offset_q <= i_set.data;
        radar_pkg::REG_TX_IDLE:           tx_idle_q     <= i_set.data;
        radar_pkg::REG_LOOPBACK:          loopback_q    <= i_set.data[0];
        radar_pkg::REG_TEST:              test_q        <= i_set.data;
        // readback-only and unmapped addresses write nothing
        default: ;
      endcase
    end
  end

  // readback mux, same-cycle
  always_comb begin
    case (i_rb_addr)
      radar_pkg::REG_RUN:               o_rb_data = {{(radar_pkg::REG_W-1){1'b0}}, run_q};
      radar_pkg::REG_PRF_COUNT:         o_rb_data = prf_count_q;
      radar_pkg::REG_ADC_SAMPLES:       o_rb_data = adc_samples_q;
      radar_pkg::REG_CHIRP_COUNT_MAX:   o_rb_data = count_max_q;
      radar_pkg::REG_CHIRP_TUNING:      o_rb_data = tuning_q;
      radar_pkg::REG_CHIRP_FREQ_OFFSET: o_rb_data = freq_offset_q;
      radar_pkg::REG_TX_IDLE:           o_rb_data = tx_idle_q;
      radar_pkg::REG_LOOPBACK:          o_rb_data = {{(radar_pkg::REG_W-1){1'b0}}, loopback_q};
      radar_pkg::REG_TEST:              o_rb_data = test_q;
      radar_pkg::RB_PULSE_COUNT:        o_rb_data = i_pulse_count;
      // live words, tx i in the upper half and rx i in the lower half
      radar_pkg::RB_TXRX:               o_rb_data = {i_tx.i, i_rx.i};
      default:                          o_rb_data = '0;
    endcase
  end

  assign o_pulse_cfg = '{run: run_q, prf_count: prf_count_q, adc_samples: adc_samples_q};
  assign o_chirp_cfg = '{count_max: count_max_q, tuning: tuning_q, freq_offset: freq_offset_q};
  assign o_tx_idle   = tx_idle_q;
  assign o_loopback  = loopback_q;

endmodule

// File: pulse_ctrl/radar_pulse_controller.sv
// radar pulse controller, times the repetition interval and launches chirps
module radar_pulse_controller (
  input  logic                        clk,
  input  logic                        i_reset,
  input  radar_pkg::pulse_cfg_t       i_pulse_cfg,
  input  logic                        i_chirp_busy,
  output logic                        o_chirp_start,
  output logic [radar_pkg::REG_W-1:0] o_pulse_count
);

  radar_pkg::pulse_state_e     state;
  logic [radar_pkg::REG_W-1:0] prf_cnt;
  logic                        prf_wrap;

  // interval ends every prf_count+1 cycles
  assign prf_wrap = (prf_cnt == i_pulse_cfg.prf_count);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state         <= radar_pkg::ST_IDLE;
      prf_cnt       <= '0;
      o_pulse_count <= '0;
    end else if (!i_pulse_cfg.run) begin
      // stopping aborts the interval, count is kept
      state   <= radar_pkg::ST_IDLE;
      prf_cnt <= '0;
    end else begin
      case (state)
        radar_pkg::ST_IDLE: begin
          state   <= radar_pkg::ST_COUNT;
          prf_cnt <= '0;
        end
        radar_pkg::ST_COUNT: begin
          if (prf_wrap) begin
            prf_cnt <= '0;
            // generator still bursting, this pulse is dropped
            if (!i_chirp_busy) begin
              state         <= radar_pkg::ST_FIRE;
              o_pulse_count <= o_pulse_count + 1'b1;
            end
          end else begin
            prf_cnt <= prf_cnt + 1'b1;
          end
        end
        radar_pkg::ST_FIRE: begin
          // fire cycle is the first cycle of the next interval
          state   <= radar_pkg::ST_COUNT;
          prf_cnt <= prf_wrap ? '0 : prf_cnt + 1'b1;
        end
        default: begin
          state   <= radar_pkg::ST_IDLE;
          prf_cnt <= '0;
        end
      endcase
    end
  end

  // one-cycle launch strobe
  // busy was low on entry and only this strobe can raise it
  assign o_chirp_start = (state == radar_pkg::ST_FIRE);

endmodule

// File: wavegen/chirp_generator.sv
// linear-FM chirp generator, phase accumulator producing one sawtooth i/q burst
module chirp_generator (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_start,
  input  radar_pkg::chirp_cfg_t i_cfg,
  output radar_pkg::chirp_beat_t o_beat,
  output logic                  o_busy
);

  localparam int PH_TOP = radar_pkg::REG_W - 1;

  radar_pkg::chirp_cfg_t       cfg_q;
  logic [radar_pkg::REG_W-1:0] phase_q;
  logic [radar_pkg::REG_W-1:0] freq_q;
  logic [radar_pkg::REG_W-1:0] beat_idx_q;
  logic                        active_q;

  // working values for the beat produced this cycle
  logic [radar_pkg::REG_W-1:0] cur_phase;
  logic [radar_pkg::REG_W-1:0] cur_freq;
  logic [radar_pkg::REG_W-1:0] cur_tuning;
  logic [radar_pkg::REG_W-1:0] cur_max;
  logic [radar_pkg::REG_W-1:0] cur_idx;
  logic                        stepping;
  logic                        final_beat;

  logic                        beat_valid;
  logic                        beat_last;
  radar_pkg::sample_iq_t       beat_sample;

  // start takes beat 0 straight from the new config
  always_comb begin
    if (i_start) begin
      cur_phase  = '0;
      cur_freq   = i_cfg.freq_offset;
      cur_tuning = i_cfg.tuning;
      cur_max    = i_cfg.count_max;
      cur_idx    = '0;
    end else begin
      cur_phase  = phase_q;
      cur_freq   = freq_q;
      cur_tuning = cfg_q.tuning;
      cur_max    = cfg_q.count_max;
      cur_idx    = beat_idx_q;
    end
  end

  assign stepping   = i_start | active_q;
  assign final_beat = (cur_idx == cur_max);

  // burst control
  always_ff @(posedge clk) begin
    if (i_reset) begin
      active_q   <= 1'b0;
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= stepping;
      beat_last  <= stepping & final_beat;
      active_q   <= stepping & ~final_beat;
    end
  end

  // accumulator and sample path
  always_ff @(posedge clk) begin
    if (i_start) begin
      cfg_q <= i_cfg;
    end
    if (stepping) begin
      // phase advances by freq_k after use, freq_k grows by tuning
      phase_q       <= cur_phase + cur_freq;
      freq_q        <= cur_freq + cur_tuning;
      beat_idx_q    <= cur_idx + 1'b1;
      beat_sample.i <= cur_phase[PH_TOP -: radar_pkg::SAMPLE_W];
      beat_sample.q <= cur_phase[PH_TOP -: radar_pkg::SAMPLE_W] + radar_pkg::QUARTER_TURN;
    end
  end

  assign o_beat = '{valid: beat_valid, last: beat_last, sample: beat_sample};
  // busy spans first beat through last
  assign o_busy = beat_valid;

endmodule

// File: wavegen/tx_output_stage.sv
// tx output stage, aligns the chirp burst to the dac and fills gaps with the idle word
module tx_output_stage (
  input  logic                   clk,
  input  logic                   i_reset,
  input  radar_pkg::chirp_beat_t i_beat,
  input  radar_pkg::sample_iq_t  i_tx_idle,
  output radar_pkg::sample_iq_t  o_tx
);

  // stage 0 is the output register, stages 1..TX_DELAY the delay line
  logic [radar_pkg::TX_DELAY:0] valid_pipe;
  radar_pkg::sample_iq_t        sample_pipe [radar_pkg::TX_DELAY+1];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[radar_pkg::TX_DELAY-1:0], i_beat.valid};
    end
  end

  always_ff @(posedge clk) begin
    sample_pipe[0] <= i_beat.sample;
    for (int k = 1; k <= radar_pkg::TX_DELAY; k++) begin
      sample_pipe[k] <= sample_pipe[k-1];
    end
  end

  // generator beat reaches the dac 4 cycles later
  assign o_tx = valid_pipe[radar_pkg::TX_DELAY] ? sample_pipe[radar_pkg::TX_DELAY] : i_tx_idle;

endmodule

// File: verilog/radar_sample_synchronizer.sv
// radar sample synchronizer, windows the rx stream per chirp and pairs it with tx
module radar_sample_synchronizer (
  input  logic                  clk,
  input  logic                  i_reset,
  input  radar_pkg::pulse_cfg_t i_pulse_cfg,
  input  logic                  i_chirp_start,
  input  logic                  i_loopback,
  input  radar_pkg::sample_iq_t i_tx,
  input  logic                  i_tx_stb,
  input  radar_pkg::sample_iq_t i_rx,
  input  logic                  i_rx_stb,
  output radar_pkg::iq_beat_t   o_iq,
  output logic                  o_iq_valid
);

  radar_pkg::sample_iq_t       rx_sample;
  logic                        rx_stb;
  logic                        win_open;
  logic [radar_pkg::REG_W-1:0] win_left;
  logic                        first_pend;
  logic                        capture;
  logic                        iq_first;
  logic                        iq_last;
  radar_pkg::sample_iq_t       dac_q;
  radar_pkg::sample_iq_t       adc_q;

  // digital loopback tx -> rx
  assign rx_sample = i_loopback ? i_tx : i_rx;
  assign rx_stb    = i_loopback ? i_tx_stb : i_rx_stb;

  // window opens the cycle after chirp_start
  assign capture = win_open & rx_stb;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      win_open   <= 1'b0;
      win_left   <= '0;
      first_pend <= 1'b0;
      o_iq_valid <= 1'b0;
      iq_first   <= 1'b0;
      iq_last    <= 1'b0;
    end else begin
      o_iq_valid <= capture;
      iq_first   <= capture & first_pend;
      iq_last    <= capture & (win_left == 1);
      if (!win_open) begin
        // empty window never opens
        if (i_chirp_start && i_pulse_cfg.run && i_pulse_cfg.adc_samples != 0) begin
          win_open   <= 1'b1;
          win_left   <= i_pulse_cfg.adc_samples;
          first_pend <= 1'b1;
        end
      end else if (rx_stb) begin
        // starts inside an open window are ignored
        first_pend <= 1'b0;
        win_left   <= win_left - 1'b1;
        if (win_left == 1) begin
          win_open <= 1'b0;
        end
      end
    end
  end

  // tx and rx words of the strobe cycle
  always_ff @(posedge clk) begin
    if (capture) begin
      dac_q <= i_tx;
      adc_q <= rx_sample;
    end
  end

  assign o_iq = '{first: iq_first, last: iq_last, dac: dac_q, adc: adc_q};

endmodule

// File: verilog/radar_core.sv
// radar core top, settings, pulse timing, chirp generation, tx and rx sync
module radar_core (
  input  logic                        clk,
  input  logic                        i_reset,
  input  radar_pkg::set_bus_t         i_set,
  input  radar_pkg::radar_reg_e       i_rb_addr,
  output logic [radar_pkg::REG_W-1:0] o_rb_data,
  input  radar_pkg::sample_iq_t       i_rx,
  input  logic                        i_rx_stb,
  input  logic                        i_tx_stb,
  output radar_pkg::sample_iq_t       o_tx,
  output radar_pkg::iq_beat_t         o_iq,
  output logic                        o_iq_valid
);

  radar_pkg::pulse_cfg_t       pulse_cfg;
  radar_pkg::chirp_cfg_t       chirp_cfg;
  radar_pkg::sample_iq_t       tx_idle;
  logic                        loopback;
  logic [radar_pkg::REG_W-1:0] pulse_count;
  logic                        chirp_start;
  logic                        chirp_busy;
  radar_pkg::chirp_beat_t      chirp_beat;

  // register bank and readback
  radar_settings radar_settings_inst (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_set         (i_set),
    .i_rb_addr     (i_rb_addr),
    .i_pulse_count (pulse_count),
    .i_tx          (o_tx),
    .i_rx          (i_rx),
    .o_rb_data     (o_rb_data),
    .o_pulse_cfg   (pulse_cfg),
    .o_chirp_cfg   (chirp_cfg),
    .o_tx_idle     (tx_idle),
    .o_loopback    (loopback)
  );

  // pulse repetition timing
  radar_pulse_controller radar_pulse_controller_inst (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_pulse_cfg   (pulse_cfg),
    .i_chirp_busy  (chirp_busy),
    .o_chirp_start (chirp_start),
    .o_pulse_count (pulse_count)
  );

  // waveform source
  chirp_generator chirp_generator_inst (
    .clk     (clk),
    .i_reset (i_reset),
    .i_start (chirp_start),
    .i_cfg   (chirp_cfg),
    .o_beat  (chirp_beat),
    .o_busy  (chirp_busy)
  );

  // dac path
  tx_output_stage tx_output_stage_inst (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_beat    (chirp_beat),
    .i_tx_idle (tx_idle),
    .o_tx      (o_tx)
  );

  // receive window and tx/rx pairing
  radar_sample_synchronizer radar_sample_synchronizer_inst (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_pulse_cfg   (pulse_cfg),
    .i_chirp_start (chirp_start),
    .i_loopback    (loopback),
    .i_tx          (o_tx),
    .i_tx_stb      (i_tx_stb),
    .i_rx          (i_rx),
    .i_rx_stb      (i_rx_stb),
    .o_iq          (o_iq),
    .o_iq_valid    (o_iq_valid)
  );

endmodule

// File: verif/radar_core_assert.sv
// protocol checks on the radar core iq stream and chirp launch
module radar_core_assert (
  input logic                   clk,
  input logic                   i_reset,
  input logic                   i_iq_valid,
  input radar_pkg::iq_beat_t    i_iq,
  input radar_pkg::chirp_beat_t i_chirp_beat,
  input logic                   i_chirp_busy,
  input logic                   i_chirp_start
);
  timeunit 1ns;
  timeprecision 100ps;

  // first flag only rides on a valid beat
  first_needs_valid: assert property (@(posedge clk) disable iff (i_reset)
    i_iq.first |-> i_iq_valid)
    else $error("iq first flag without iq valid");

  chirp_last_needs_valid: assert property (@(posedge clk) disable iff (i_reset)
    i_chirp_beat.last |-> i_chirp_beat.valid)
    else $error("chirp last flag without chirp valid");

  // launch only into an idle generator
  start_not_busy: assert property (@(posedge clk) disable iff (i_reset)
    i_chirp_start |-> !i_chirp_busy)
    else $error("chirp start while generator busy");

endmodule

bind radar_core radar_core_assert radar_core_assert_inst (
  .clk           (clk),
  .i_reset       (i_reset),
  .i_iq_valid    (o_iq_valid),
  .i_iq          (o_iq),
  .i_chirp_beat  (chirp_beat),
  .i_chirp_busy  (chirp_busy),
  .i_chirp_start (chirp_start)
);

// File: verif/radar_core_tb.sv
// radar core testbench running directed tests of settings, chirp, pulse rate and loopback
module radar_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                        clk = 1'b0;
  logic                        i_reset;
  radar_pkg::set_bus_t         i_set;
  radar_pkg::radar_reg_e       i_rb_addr;
  logic [radar_pkg::REG_W-1:0] o_rb_data;
  radar_pkg::sample_iq_t       i_rx;
  logic                        i_rx_stb;
  logic                        i_tx_stb;
  radar_pkg::sample_iq_t       o_tx;
  radar_pkg::iq_beat_t         o_iq;
  logic                        o_iq_valid;

  int                          mismatch_count = 0;
  int                          failure_count = 0;
  logic [31:0]                 lfsr_state = 32'hfaee852c;
  // chirp settings shared by the burst tests
  logic [31:0]                 chirp_tuning = 32'h0020_0000;
  logic [31:0]                 chirp_offset = 32'h0100_0000;
  radar_pkg::sample_iq_t       idle_word = 32'hdeadbeef;
  // expected burst rebuilt from the phase rule
  radar_pkg::sample_iq_t       chirp_ref [64];

  // 8 ns period
  always #4 clk = ~clk;

  radar_core radar_core_inst (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_set      (i_set),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .i_rx       (i_rx),
    .i_rx_stb   (i_rx_stb),
    .i_tx_stb   (i_tx_stb),
    .o_tx       (o_tx),
    .o_iq       (o_iq),
    .o_iq_valid (o_iq_valid)
  );

  // inputs change 1 ns past the rising edge where outputs are settled
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic reset_dut();
    i_reset = 1'b1;
    repeat (2) next_cycle();
    i_reset = 1'b0;
  endtask

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic random_word(output logic [31:0] word);
    word = '0;
    for (int b = 0; b < 32; b++) begin
      word = {word[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic report_failure(input string what);
    failure_count++;
    $display("FAILURE %s", what);
  endtask

  task automatic check_word(input string name, input logic [radar_pkg::REG_W-1:0] expected,
                            input logic [radar_pkg::REG_W-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_sample(input string name, input radar_pkg::sample_iq_t expected,
                              input radar_pkg::sample_iq_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_beat(input string name, input radar_pkg::iq_beat_t expected,
                            input radar_pkg::iq_beat_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // single-cycle strobe and the register holds the value from the next cycle
  task automatic write_reg(input radar_pkg::radar_reg_e addr, input logic [31:0] data);
    i_set = '{stb: 1'b1, addr: addr, data: data};
    next_cycle();
    i_set.stb = 1'b0;
  endtask

  task automatic read_reg(input radar_pkg::radar_reg_e addr, output logic [31:0] data);
    i_rb_addr = addr;
    next_cycle();
    data = o_rb_data;
  endtask

  // phase starts at 0 and grows by freq_k = offset + k*tuning after each use
  task automatic build_chirp(input logic [31:0] offset, input logic [31:0] tuning,
                             input int beats);
    logic [31:0] phase;
    logic [31:0] freq;
    phase = '0;
    freq  = offset;
    for (int k = 0; k < beats; k++) begin
      chirp_ref[k].i = phase[31:16];
      chirp_ref[k].q = phase[31:16] + radar_pkg::QUARTER_TURN;
      phase = phase + freq;
      freq  = freq + tuning;
    end
  endtask

  task automatic configure_pulse(input logic [31:0] count_max, input logic [31:0] prf,
                                 input logic [31:0] adc_samples);
    write_reg(radar_pkg::REG_CHIRP_COUNT_MAX, count_max);
    write_reg(radar_pkg::REG_CHIRP_TUNING, chirp_tuning);
    write_reg(radar_pkg::REG_CHIRP_FREQ_OFFSET, chirp_offset);
    write_reg(radar_pkg::REG_PRF_COUNT, prf);
    write_reg(radar_pkg::REG_ADC_SAMPLES, adc_samples);
    write_reg(radar_pkg::REG_TX_IDLE, idle_word);
    build_chirp(chirp_offset, chirp_tuning, int'(count_max) + 1);
  endtask

  // idle to non-idle edge on o_tx marks a burst start
  task automatic wait_burst_start(input int limit, output bit ok, output int cycles);
    radar_pkg::sample_iq_t prev;
    prev   = o_tx;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < limit) begin
      next_cycle();
      cycles++;
      ok   = (prev === idle_word) && (o_tx !== idle_word);
      prev = o_tx;
    end
    if (!ok) begin
      report_failure($sformatf("no chirp burst on o_tx within %0d cycles", limit));
    end
  endtask

  task automatic wait_iq_valid(input int limit, output bit ok);
    int cycles;
    cycles = 0;
    while (o_iq_valid !== 1'b1 && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    ok = (o_iq_valid === 1'b1);
    if (!ok) begin
      report_failure($sformatf("o_iq_valid never rose within %0d cycles", limit));
    end
  endtask

  task automatic test_reset_state();
    logic [31:0] rb;
    reset_dut();
    check_word("reset o_iq_valid", 32'd0, 32'(o_iq_valid));
    check_sample("reset o_tx", '0, o_tx);
    read_reg(radar_pkg::RB_PULSE_COUNT, rb);
    check_word("reset pulse count", 32'd0, rb);
  endtask

  task automatic test_register_readback();
    radar_pkg::radar_reg_e regs [7];
    logic [31:0]           written [7];
    logic [31:0]           rb;
    regs = '{radar_pkg::REG_PRF_COUNT, radar_pkg::REG_ADC_SAMPLES,
             radar_pkg::REG_CHIRP_COUNT_MAX, radar_pkg::REG_CHIRP_TUNING,
             radar_pkg::REG_CHIRP_FREQ_OFFSET, radar_pkg::REG_TX_IDLE, radar_pkg::REG_TEST};
    // all writes first so an address alias shows up
    for (int k = 0; k < 7; k++) begin
      random_word(written[k]);
      write_reg(regs[k], written[k]);
    end
    for (int k = 0; k < 7; k++) begin
      read_reg(regs[k], rb);
      check_word($sformatf("readback %s", regs[k].name()), written[k], rb);
    end
  endtask

  task automatic test_idle_word();
    write_reg(radar_pkg::REG_TX_IDLE, idle_word);
    for (int k = 0; k < 20; k++) begin
      check_sample($sformatf("idle word cycle %0d", k), idle_word, o_tx);
      next_cycle();
    end
  endtask

  task automatic test_chirp_burst();
    bit ok;
    int cycles;
    configure_pulse(32'd7, 32'd200, 32'd0);
    write_reg(radar_pkg::REG_RUN, 32'd1);
    wait_burst_start(300, ok, cycles);
    if (!ok) begin
      return;
    end
    for (int k = 0; k < 8; k++) begin
      check_sample($sformatf("chirp beat %0d", k), chirp_ref[k], o_tx);
      next_cycle();
    end
    check_sample("chirp end idle", idle_word, o_tx);
    write_reg(radar_pkg::REG_RUN, 32'd0);
  endtask

  task automatic test_pulse_rate();
    bit          ok;
    int          cycles;
    logic [31:0] expected_count;
    reset_dut();
    configure_pulse(32'd7, 32'd40, 32'd0);
    i_rb_addr = radar_pkg::RB_PULSE_COUNT;
    write_reg(radar_pkg::REG_RUN, 32'd1);
    wait_burst_start(200, ok, cycles);
    if (!ok) begin
      return;
    end
    expected_count = 32'd1;
    check_word("first pulse count", expected_count, o_rb_data);
    for (int p = 0; p < 3; p++) begin
      wait_burst_start(100, ok, cycles);
      if (!ok) begin
        return;
      end
      // prf_count + 1 cycles per interval
      check_word($sformatf("burst spacing %0d", p), 32'd41, cycles);
      // one more pulse fired per burst
      expected_count = expected_count + 32'd1;
      check_word($sformatf("pulse count %0d", p), expected_count, o_rb_data);
    end
    write_reg(radar_pkg::REG_RUN, 32'd0);
  endtask

  task automatic test_loopback_capture();
    bit                    ok;
    radar_pkg::iq_beat_t   expected;
    radar_pkg::sample_iq_t tx_word;
    reset_dut();
    configure_pulse(32'd15, 32'd60, 32'd5);
    write_reg(radar_pkg::REG_LOOPBACK, 32'd1);
    i_tx_stb = 1'b1;
    write_reg(radar_pkg::REG_RUN, 32'd1);
    for (int p = 0; p < 2; p++) begin
      wait_iq_valid(200, ok);
      if (!ok) begin
        return;
      end
      for (int n = 0; n < 5; n++) begin
        // beat n pairs o_tx of chirp_start+1+n and the burst reaches o_tx at chirp_start+5
        if (n >= 4) begin
          tx_word = chirp_ref[n-4];
        end else begin
          tx_word = idle_word;
        end
        expected = '{first: (n == 0), last: (n == 4), dac: tx_word, adc: tx_word};
        if (o_iq_valid !== 1'b1) begin
          report_failure($sformatf("pulse %0d window ended early at beat %0d", p, n));
        end
        check_beat($sformatf("pulse %0d beat %0d", p, n), expected, o_iq);
        next_cycle();
      end
      check_word($sformatf("pulse %0d valid after window", p), 32'd0, 32'(o_iq_valid));
    end
    i_tx_stb = 1'b0;
    write_reg(radar_pkg::REG_RUN, 32'd0);
  endtask

  initial begin
    i_reset   = 1'b1;
    i_set     = '0;
    i_rb_addr = radar_pkg::RB_PULSE_COUNT;
    i_rx      = '0;
    i_rx_stb  = 1'b0;
    i_tx_stb  = 1'b0;

    test_reset_state();
    test_register_readback();
    test_idle_word();
    test_chirp_burst();
    test_pulse_rate();
    test_loopback_capture();

    $display("mismatches %0d, other failures %0d", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/radar_pkg.sv
verilog/radar_settings.sv
pulse_ctrl/radar_pulse_controller.sv
wavegen/chirp_generator.sv
wavegen/tx_output_stage.sv
verilog/radar_sample_synchronizer.sv
verilog/radar_core.sv
verif/radar_core_assert.sv
verif/radar_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the radar core testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f filelist.f --top-module radar_core_tb \
  -Mdir obj_dir -o radar_core_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/radar_core_sim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
